// ==== rtl/pkt_buf_pkg.sv ====
// Shared widths and types; PKT_MAX_BEATS must not exceed 2**RAM_ADDR_W, SEQ_W + LEN_W == DATA_W
`default_nettype none

package pkt_buf_pkg;

  // ------------------------------------------------------------
  // Widths and sizes
  // ------------------------------------------------------------
  // Payload width of every stream beat
  localparam int DATA_W = 32;
  // Gate RAM holds 2**RAM_ADDR_W words
  localparam int RAM_ADDR_W = 7;
  // Longer packets are cut at this beat and dropped
  localparam int PKT_MAX_BEATS = 64;
  localparam int LEN_W = 16;
  localparam int SEQ_W = 16;
  // Width of the drop and sent packet counters
  localparam int CNT_W = 32;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  // One word of the gate RAM with the end-of-packet flag above the data
  typedef struct packed {
    logic              last;
    logic [DATA_W-1:0] data;
  } ram_word_t;

  typedef logic [LEN_W-1:0] pkt_len_t;

  // Header beat with the sequence number in the upper half
  typedef struct packed {
    logic [SEQ_W-1:0] seq;
    logic [LEN_W-1:0] len;
  } hdr_t;

endpackage

`default_nettype wire

// ==== rtl/pkt_stream_if.sv ====
// Valid/ready beat stream; error has meaning only on the beat that carries last
`timescale 1ns/100ps
`default_nettype none

interface pkt_stream_if;

  // Beat payload
  logic [pkt_buf_pkg::DATA_W-1:0] data;
  // End of packet marker
  logic last;
  // Packet is bad, sampled together with last
  logic error;
  logic valid;
  logic ready;

  // Producer side
  modport src (output data, last, error, valid, input ready);

  // Consumer side
  modport snk (input data, last, error, valid, output ready);

endinterface

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
// Register-array FIFO with first-word fall-through output; DEPTH must be at least 2
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic i_reset,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic push;
  logic pop;

  // Full and empty come straight from the occupancy count
  assign o_ready = (count != CNT_W'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign push    = i_valid & o_ready;
  assign pop     = o_valid & i_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push & ~pop) begin
        count <= count + 1'b1;
      end else if (pop & ~push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pkt_ram.sv ====
// Simple dual-port RAM, registered read; reading the address being written returns old data
`timescale 1ns/100ps
`default_nettype none

module pkt_ram #(
  parameter int ADDR_W = pkt_buf_pkg::RAM_ADDR_W
) (
  input  logic                   clk,
  input  logic                   i_wr_en,
  input  logic [ADDR_W-1:0]      i_wr_addr,
  input  pkt_buf_pkg::ram_word_t i_wr_data,
  input  logic                   i_rd_en,
  input  logic [ADDR_W-1:0]      i_rd_addr,
  output pkt_buf_pkg::ram_word_t o_rd_data
);

  pkt_buf_pkg::ram_word_t mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read word is held until the next read enable
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pkt_parity_check.sv ====
// Input stage; even parity per beat, packets over PKT_MAX_BEATS are cut, tail discarded, dropped
`timescale 1ns/100ps
`default_nettype none

module pkt_parity_check (
  input  logic                               clk,
  input  logic                               i_reset,
  input  logic [pkt_buf_pkg::DATA_W-1:0]     i_data,
  input  logic                               i_parity,
  input  logic                               i_last,
  input  logic                               i_valid,
  output logic                               o_ready,
  pkt_stream_if.src                          o_stream,
  output logic [pkt_buf_pkg::CNT_W-1:0]      o_drop_count
);

  logic beat_bad;
  logic at_limit;
  logic trunc;
  logic fwd_xfer;
  logic accept_en;
  logic discarding;
  logic err_sticky;
  pkt_buf_pkg::pkt_len_t beat_cnt;

  // ------------------------------------------------------------
  // Combinational data path
  // ------------------------------------------------------------
  // Odd parity over data plus parity bit marks a bad beat
  assign beat_bad = ^{i_data, i_parity};
  // This beat is number PKT_MAX_BEATS of the packet
  assign at_limit = (beat_cnt == pkt_buf_pkg::pkt_len_t'(pkt_buf_pkg::PKT_MAX_BEATS - 1));
  assign trunc    = at_limit & ~i_last;

  assign o_stream.data  = i_data;
  assign o_stream.last  = i_last | at_limit;
  // Error collects every bad beat so far, read by the gate only with last
  assign o_stream.error = err_sticky | beat_bad | trunc;
  assign o_stream.valid = accept_en & i_valid & ~discarding;
  // While the tail of a cut packet is thrown away, input is always taken
  assign o_ready  = accept_en & (discarding | o_stream.ready);
  assign fwd_xfer = o_stream.valid & o_stream.ready;

  // ------------------------------------------------------------
  // Packet tracking
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_reset) begin
      accept_en    <= 1'b0;
      discarding   <= 1'b0;
      err_sticky   <= 1'b0;
      beat_cnt     <= '0;
      o_drop_count <= '0;
    end else begin
      // Input opens one cycle after reset is released
      accept_en <= 1'b1;
      if (fwd_xfer) begin
        if (o_stream.last) begin
          beat_cnt   <= '0;
          err_sticky <= 1'b0;
          discarding <= trunc;
          if (o_stream.error) begin
            o_drop_count <= o_drop_count + 1'b1;
          end
        end else begin
          beat_cnt   <= beat_cnt + 1'b1;
          err_sticky <= err_sticky | beat_bad;
        end
      end
      // The input last of a cut packet ends the discard
      if (discarding & i_valid & i_last) begin
        discarding <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pkt_gate.sv ====
// Packet gate buffer; packets must not exceed 2**ADDR_W beats, bad packets are removed on last
`timescale 1ns/100ps
`default_nettype none

module pkt_gate #(
  parameter int ADDR_W = pkt_buf_pkg::RAM_ADDR_W
) (
  input  logic                  clk,
  input  logic                  i_reset,
  pkt_stream_if.snk             i_stream,
  pkt_stream_if.src             o_stream,
  output pkt_buf_pkg::pkt_len_t o_len,
  output logic                  o_len_valid,
  input  logic                  i_len_ready
);

  localparam int DEPTH = 2 ** ADDR_W;

  typedef logic [ADDR_W-1:0] addr_t;

  addr_t wr_addr;
  addr_t wr_head_addr;
  addr_t rd_addr;
  addr_t rd_addr_nxt;
  addr_t afifo_out_data;
  logic wr_en;
  logic rd_en;
  logic good_last;
  logic bad_last;
  logic ram_full;
  logic ram_empty;
  logic almost_full;
  logic almost_empty;
  logic afifo_in_ready;
  logic lfifo_in_ready;
  logic afifo_out_valid;
  logic afifo_out_ready;
  logic ready_to_read;
  logic rd_data_valid;
  logic update_out_reg;
  pkt_buf_pkg::ram_word_t wr_word;
  pkt_buf_pkg::ram_word_t rd_word;
  pkt_buf_pkg::pkt_len_t wr_beats;

  pkt_ram #(.ADDR_W(ADDR_W)) ram_i (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_word),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_word)
  );

  // Holds the address of the final word of every stored good packet
  sync_fifo #(.T(addr_t), .DEPTH(DEPTH)) addr_fifo_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_data  (wr_addr),
    .i_valid (good_last),
    .o_ready (afifo_in_ready),
    .o_data  (afifo_out_data),
    .o_valid (afifo_out_valid),
    .i_ready (afifo_out_ready)
  );

  // Beat count of each stored good packet, popped by the framer
  sync_fifo #(.T(pkt_buf_pkg::pkt_len_t), .DEPTH(DEPTH)) len_fifo_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_data  (wr_beats + 1'b1),
    .i_valid (good_last),
    .o_ready (lfifo_in_ready),
    .o_data  (o_len),
    .o_valid (o_len_valid),
    .i_ready (i_len_ready)
  );

  // ------------------------------------------------------------
  // Occupancy flags
  // ------------------------------------------------------------
  // Pointers are equal when both full and empty, so the side they approach from decides
  assign almost_full  = (wr_addr == rd_addr - 1'b1);
  assign almost_empty = (wr_addr == rd_addr + 1'b1);
  assign rd_addr_nxt  = rd_en ? rd_addr + 1'b1 : rd_addr;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      ram_full  <= 1'b0;
      ram_empty <= 1'b1;
    end else if (bad_last) begin
      // The rewind frees at least the bad beat, and only good data remain
      ram_full  <= 1'b0;
      ram_empty <= (wr_head_addr == rd_addr_nxt);
    end else begin
      if (almost_full & wr_en & ~rd_en) begin
        ram_full <= 1'b1;
      end else if (~almost_full & rd_en & ~wr_en) begin
        ram_full <= 1'b0;
      end
      if (almost_empty & rd_en & ~wr_en) begin
        ram_empty <= 1'b1;
      end else if (~almost_empty & wr_en & ~rd_en) begin
        ram_empty <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------
  assign i_stream.ready = ~ram_full & afifo_in_ready & lfifo_in_ready;
  assign wr_en          = i_stream.valid & i_stream.ready;
  assign good_last      = wr_en & i_stream.last & ~i_stream.error;
  assign bad_last       = wr_en & i_stream.last & i_stream.error;
  assign wr_word.last   = i_stream.last;
  assign wr_word.data   = i_stream.data;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_addr      <= '0;
      wr_head_addr <= '0;
      wr_beats     <= '0;
    end else if (wr_en) begin
      wr_beats <= i_stream.last ? '0 : wr_beats + 1'b1;
      if (bad_last) begin
        // Forget the whole packet by returning to its first word
        wr_addr <= wr_head_addr;
      end else begin
        wr_addr <= wr_addr + 1'b1;
        if (i_stream.last) begin
          wr_head_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------
  // Reading starts only once a complete good packet sits in the RAM
  assign ready_to_read   = ~ram_empty & afifo_out_valid;
  assign rd_en           = ready_to_read & (update_out_reg | ~rd_data_valid);
  // The address entry leaves when its final word is read
  assign afifo_out_ready = rd_en & (afifo_out_data == rd_addr);
  assign update_out_reg  = o_stream.ready | ~o_stream.valid;
  assign o_stream.error  = 1'b0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      rd_addr        <= '0;
      rd_data_valid  <= 1'b0;
      o_stream.valid <= 1'b0;
    end else begin
      rd_addr <= rd_addr_nxt;
      if (update_out_reg | ~rd_data_valid) begin
        rd_data_valid <= ready_to_read;
      end
      if (update_out_reg) begin
        o_stream.valid <= rd_data_valid;
      end
    end
  end

  // Output register loads only after its beat has been taken
  always_ff @(posedge clk) begin
    if (update_out_reg) begin
      o_stream.data <= rd_word.data;
      o_stream.last <= rd_word.last;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pkt_header_framer.sv ====
// Output stage; registered output, one header beat before every packet, sequence wraps at 2**SEQ_W
`timescale 1ns/100ps
`default_nettype none

module pkt_header_framer (
  input  logic                           clk,
  input  logic                           i_reset,
  pkt_stream_if.snk                      i_stream,
  input  pkt_buf_pkg::pkt_len_t          i_len,
  input  logic                           i_len_valid,
  output logic                           o_len_ready,
  output logic [pkt_buf_pkg::DATA_W-1:0] o_data,
  output logic                           o_last,
  output logic                           o_valid,
  input  logic                           i_ready,
  output logic [pkt_buf_pkg::CNT_W-1:0]  o_sent_count
);

  typedef enum logic {HEADER, BODY} state_t;

  state_t state;
  pkt_buf_pkg::hdr_t header;
  logic [pkt_buf_pkg::SEQ_W-1:0] seq;
  logic update;

  // The output register may load when empty or when its beat goes out
  assign update = i_ready | ~o_valid;

  // A length is popped in HEADER, data beats are taken in BODY
  assign o_len_ready    = (state == HEADER) & update;
  assign i_stream.ready = (state == BODY) & update;

  assign header.seq = seq;
  assign header.len = i_len;

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state   <= HEADER;
      seq     <= '0;
      o_valid <= 1'b0;
    end else if (update) begin
      case (state)
        HEADER: begin
          o_valid <= i_len_valid;
          if (i_len_valid) begin
            state <= BODY;
          end
        end
        BODY: begin
          o_valid <= i_stream.valid;
          // Next packet gets the next sequence number
          if (i_stream.valid & i_stream.last) begin
            state <= HEADER;
            seq   <= seq + 1'b1;
          end
        end
      endcase
    end
  end

  // Beat held unchanged under back-pressure
  always_ff @(posedge clk) begin
    if (update) begin
      if (state == HEADER) begin
        o_data <= header;
        o_last <= 1'b0;
      end else begin
        o_data <= i_stream.data;
        o_last <= i_stream.last;
      end
    end
  end

  // Counts packets whose final beat has left the output
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_sent_count <= '0;
    end else if (o_valid & i_ready & o_last) begin
      o_sent_count <= o_sent_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pkt_buffer_top.sv ====
// Packet buffer top; input needs even parity per beat, input ready rises a cycle after reset
`timescale 1ns/100ps
`default_nettype none

module pkt_buffer_top (
  input  logic                           clk,
  input  logic                           i_reset,
  input  logic [pkt_buf_pkg::DATA_W-1:0] i_data,
  input  logic                           i_parity,
  input  logic                           i_last,
  input  logic                           i_valid,
  output logic                           o_ready,
  output logic [pkt_buf_pkg::DATA_W-1:0] o_data,
  output logic                           o_last,
  output logic                           o_valid,
  input  logic                           i_ready,
  output logic [pkt_buf_pkg::CNT_W-1:0]  o_drop_count,
  output logic [pkt_buf_pkg::CNT_W-1:0]  o_sent_count
);

  pkt_buf_pkg::pkt_len_t len;
  logic len_valid;
  logic len_ready;

  // Checked beats into the gate, whole good packets out of it
  pkt_stream_if chk_stream ();
  pkt_stream_if gate_stream ();

  pkt_parity_check parity_check_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_data       (i_data),
    .i_parity     (i_parity),
    .i_last       (i_last),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .o_stream     (chk_stream),
    .o_drop_count (o_drop_count)
  );

  pkt_gate #(.ADDR_W(pkt_buf_pkg::RAM_ADDR_W)) gate_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_stream    (chk_stream),
    .o_stream    (gate_stream),
    .o_len       (len),
    .o_len_valid (len_valid),
    .i_len_ready (len_ready)
  );

  pkt_header_framer framer_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_stream     (gate_stream),
    .i_len        (len),
    .i_len_valid  (len_valid),
    .o_len_ready  (len_ready),
    .o_data       (o_data),
    .o_last       (o_last),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_sent_count (o_sent_count)
  );

endmodule

`default_nettype wire

// ==== verification/pkt_buffer_assertions.sv ====
// Output handshake checks bound into pkt_buffer_top; sampled on the rising clock edge only
`timescale 1ns/100ps
`default_nettype none

module pkt_buffer_assertions (
  input logic                           clk,
  input logic                           i_reset,
  input logic [pkt_buf_pkg::DATA_W-1:0] o_data,
  input logic                           o_valid,
  input logic                           i_ready
);

  // ------------------------------------------------------------
  // Output stream rules
  // ------------------------------------------------------------
  // An offered beat stays offered until the sink takes it
  valid_held: assert property (@(posedge clk) disable iff (i_reset)
    o_valid && !i_ready |=> o_valid)
    else $error("o_valid dropped while i_ready was low");

  // The beat itself may not change while it waits
  data_stable: assert property (@(posedge clk) disable iff (i_reset)
    o_valid && !i_ready |=> $stable(o_data))
    else $error("o_data changed while stalled");

  // Synchronous reset clears the output register
  valid_low_after_reset: assert property (@(posedge clk)
    i_reset |=> !o_valid)
    else $error("o_valid high in the cycle after reset");

endmodule

bind pkt_buffer_top pkt_buffer_assertions assertions_i (
  .clk     (clk),
  .i_reset (i_reset),
  .o_data  (o_data),
  .o_valid (o_valid),
  .i_ready (i_ready)
);

`default_nettype wire

// ==== verification/tb_pkt_buffer.sv ====
// Directed testbench for pkt_buffer_top; needs timing support and stops at the first error
`timescale 1ns/100ps
`default_nettype none

module tb_pkt_buffer;

  localparam logic [31:0] SEED = 32'h86786ef6;
  // Well above the cycles that all tests need together
  localparam int TIMEOUT_CYCLES = 20000;

  logic clk = 1'b0;
  logic i_reset;
  logic [pkt_buf_pkg::DATA_W-1:0] i_data;
  logic i_parity;
  logic i_last;
  logic i_valid;
  logic o_ready;
  logic [pkt_buf_pkg::DATA_W-1:0] o_data;
  logic o_last;
  logic o_valid;
  logic i_ready;
  logic [pkt_buf_pkg::CNT_W-1:0] o_drop_count;
  logic [pkt_buf_pkg::CNT_W-1:0] o_sent_count;

  // Data stream and ready stream use separate generators
  logic [31:0] rng;
  logic [31:0] rdy_rng;
  logic [15:0] next_seq;
  // Expected output beats as {is_header, last, data}
  logic [33:0] exp_q[$];
  // Good packets whose input last has transferred
  int exp_sent;
  int exp_drops;
  int hdr_out;
  int cycles;
  bit random_ready;

  pkt_buffer_top pkt_buffer_top_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_data       (i_data),
    .i_parity     (i_parity),
    .i_last       (i_last),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .o_data       (o_data),
    .o_last       (o_last),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_drop_count (o_drop_count),
    .o_sent_count (o_sent_count)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped after the first error");
  endtask

  // ------------------------------------------------------------
  // Driver
  // ------------------------------------------------------------
  // Waits for the next falling edge and moves i_ready while random back-pressure is on
  task automatic next_negedge();
    @(negedge clk);
    if (random_ready) begin
      i_ready = rdy_rng[0];
      rdy_rng = xorshift32(rdy_rng);
    end
  endtask

  // Called at a falling edge; bad_beat below zero means all beats have good parity
  task automatic send_packet(input int len, input int bad_beat, input bit expect_out);
    logic [31:0] data;
    logic last;
    if (expect_out) begin
      // The header holds the sequence number in the upper half and the beat count below
      exp_q.push_back({1'b1, 1'b0, next_seq, len[15:0]});
      next_seq = next_seq + 1'b1;
    end
    for (int i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      data = rng;
      last = (i == len - 1);
      if (expect_out) begin
        exp_q.push_back({1'b0, last, data});
      end
      i_data   = data;
      i_parity = (^data) ^ (i == bad_beat);
      i_last   = last;
      i_valid  = 1'b1;
      // Input ready only moves on a rising edge, so it is stable here
      while (!o_ready) next_negedge();
      next_negedge();
    end
    i_valid = 1'b0;
    i_last  = 1'b0;
    if (expect_out) begin
      exp_sent++;
    end else begin
      exp_drops++;
    end
  endtask

  task automatic drain_and_check_counts();
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    assert (o_sent_count == exp_sent) else
      fail_run($sformatf("MISMATCH at %0t: o_sent_count %0d, expected %0d",
                         $time, o_sent_count, exp_sent));
    assert (o_drop_count == exp_drops) else
      fail_run($sformatf("MISMATCH at %0t: o_drop_count %0d, expected %0d",
                         $time, o_drop_count, exp_drops));
  endtask

  // ------------------------------------------------------------
  // Output monitor
  // ------------------------------------------------------------
  always @(posedge clk) begin
    logic [33:0] want;
    if (!i_reset && o_valid && i_ready) begin
      assert (exp_q.size() != 0) else
        fail_run("An output beat appeared while no packet was expected");
      want = exp_q.pop_front();
      if (want[33]) begin
        // A header may only leave once its packet is complete at the input
        assert (hdr_out < exp_sent) else
          fail_run("A packet started at the output before its input last was sent");
        hdr_out++;
      end
      assert (o_data == want[31:0] && o_last == want[32]) else
        fail_run($sformatf("MISMATCH at %0t: o_data %h o_last %b, expected %h %b",
                           $time, o_data, o_last, want[31:0], want[32]));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic good_packets_in_order();
    int len;
    repeat (8) begin
      rng = xorshift32(rng);
      len = int'(rng[5:0]) + 1;
      send_packet(len, -1, 1'b1);
    end
    drain_and_check_counts();
  endtask

  // The dropped packet must leave no gap in the sequence numbers
  task automatic bad_parity_drop();
    send_packet(12, -1, 1'b1);
    send_packet(10, 4, 1'b0);
    send_packet(7, -1, 1'b1);
    send_packet(33, -1, 1'b1);
    drain_and_check_counts();
  endtask

  task automatic oversize_truncation();
    send_packet(70, -1, 1'b0);
    send_packet(5, -1, 1'b1);
    drain_and_check_counts();
  endtask

  task automatic random_backpressure();
    int len;
    random_ready = 1'b1;
    repeat (10) begin
      rng = xorshift32(rng);
      len = int'(rng[5:0]) + 1;
      send_packet(len, -1, 1'b1);
    end
    random_ready = 1'b0;
    i_ready = 1'b1;
    drain_and_check_counts();
  endtask

  // 160 beats are offered, more than the RAM and the output stages can hold
  task automatic fill_and_release();
    i_ready = 1'b0;
    fork
      repeat (10) send_packet(16, -1, 1'b1);
      begin
        while (o_ready) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (!o_ready) else
          fail_run("Input ready came back while the output was still held off");
        i_ready = 1'b1;
      end
    join
    drain_and_check_counts();
  endtask

  initial begin
    rng          = SEED;
    rdy_rng      = {SEED[15:0], SEED[31:16]};
    next_seq     = '0;
    exp_sent     = 0;
    exp_drops    = 0;
    hdr_out      = 0;
    cycles       = 0;
    random_ready = 1'b0;
    i_reset      = 1'b1;
    i_data       = '0;
    i_parity     = 1'b0;
    i_last       = 1'b0;
    i_valid      = 1'b0;
    i_ready      = 1'b1;
    // Two rising edges with reset high
    repeat (2) @(negedge clk);
    i_reset = 1'b0;
    good_packets_in_order();
    bad_parity_drop();
    oversize_truncation();
    random_backpressure();
    fill_and_release();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/pkt_buf_pkg.sv
rtl/pkt_stream_if.sv
rtl/sync_fifo.sv
rtl/pkt_ram.sv
rtl/pkt_parity_check.sv
rtl/pkt_gate.sv
rtl/pkt_header_framer.sv
rtl/pkt_buffer_top.sv
verification/pkt_buffer_assertions.sv
verification/tb_pkt_buffer.sv

// ==== Makefile ====
TOP := tb_pkt_buffer
SIM := obj_dir/V$(TOP)

.PHONY: run clean

# Rebuilt only when a source or the file list changes
$(SIM): files.f $(wildcard rtl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^ALL TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
